// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -O2
TOP       := spmv_lane_tb
FILELIST  := spmv_lane.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard source/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== source/product_stage.sv ====
`include "spmv_params.svh"

module product_stage import spmv_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  logic          start,
	input  logic          input_done,
	input  logic          vec_wr_en,
	input  col_id_t       vec_wr_addr,
	input  vec_val_t      vec_wr_data,
	input  logic          nz_wr_en,
	input  row_id_t       nz_row_id,
	input  col_id_t       nz_col_id,
	input  mat_val_t      nz_mat_val,
	output logic          nz_full,
	prod_stream_if.source prod
);

	localparam int NZ_WIDTH = `ROW_ID_BITS + `COL_ID_BITS + `MAT_VAL_BITS;
	localparam int PROD_WIDTH = `ROW_ID_BITS + `MULT_BITS;
	localparam logic [`FIFO_DEPTH_BITS:0] DEPTH = (`FIFO_DEPTH_BITS + 1)'(`FIFO_DEPTH);

	vec_val_t vec_mem [`NUM_VEC_VALS];

	logic [NZ_WIDTH-1:0] nz_head;
	row_id_t nz_row;
	col_id_t nz_col;
	mat_val_t nz_val;
	logic nz_empty;
	logic nz_pop;

	logic [PROD_WIDTH-1:0] prod_head;
	logic [`FIFO_DEPTH_BITS:0] prod_count;
	logic [`FIFO_DEPTH_BITS:0] prod_free;
	logic [1:0] in_flight;

	logic s1_valid;
	row_id_t s1_row;
	mat_val_t s1_val;
	vec_val_t s1_vec;
	logic s2_valid;
	row_id_t s2_row;
	mult_t s2_prod;
	logic input_seen;

	sync_fifo #(.width(NZ_WIDTH), .depth_bits(`FIFO_DEPTH_BITS)) nz_fifo (
		.clk(clk),
		.rst(rst),
		.din({nz_row_id, nz_col_id, nz_mat_val}),
		.wr_en(nz_wr_en),
		.rd_en(nz_pop),
		.dout(nz_head),
		.full(nz_full),
		.empty(nz_empty),
		.count()
	);

	assign {nz_row, nz_col, nz_val} = nz_head;

	// Pop only if every product in flight still finds a free slot
	assign in_flight = 2'(s1_valid) + 2'(s2_valid);
	assign prod_free = DEPTH - prod_count;
	assign nz_pop = start & ~nz_empty & (prod_free > (`FIFO_DEPTH_BITS + 1)'(in_flight));

	////////////////////
	// Pipeline control
	////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			input_seen <= 1'b0;
		end else begin
			s1_valid <= nz_pop;
			s2_valid <= s1_valid;
			input_seen <= input_seen | input_done;
		end
	end

	// Vector memory, lookup and multiply
	always_ff @(posedge clk) begin
		if (vec_wr_en)
			vec_mem[vec_wr_addr] <= vec_wr_data;
		if (nz_pop) begin
			s1_vec <= vec_mem[nz_col];
			s1_row <= nz_row;
			s1_val <= nz_val;
		end
		if (s1_valid) begin
			s2_row <= s1_row;
			s2_prod <= mult_t'(s1_val) * mult_t'(s1_vec);
		end
	end

	sync_fifo #(.width(PROD_WIDTH), .depth_bits(`FIFO_DEPTH_BITS)) prod_fifo (
		.clk(clk),
		.rst(rst),
		.din({s2_row, s2_prod}),
		.wr_en(s2_valid),
		.rd_en(prod.rd_en),
		.dout(prod_head),
		.full(),
		.empty(prod.empty),
		.count(prod_count)
	);

	assign {prod.row_id, prod.product} = prod_head;

	// Nothing left upstream of the product FIFO
	assign prod.stream_end = input_seen & nz_empty & ~s1_valid & ~s2_valid;

endmodule

// ==== source/row_accumulator.sv ====
`include "spmv_params.svh"

module row_accumulator import spmv_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  logic        out_rd_en,
	prod_stream_if.sink prod,
	output row_id_t     out_row,
	output mult_t       out_sum,
	output logic        out_empty,
	output logic        done
);

	localparam int OUT_WIDTH = `ROW_ID_BITS + `MULT_BITS;

	acc_state_t state;

	row_id_t cur_row;
	mult_t cur_sum;
	row_id_t wr_row;
	mult_t wr_sum;
	logic wr_pend;
	logic wr_load;
	logic out_wr;
	logic out_full;
	logic stall;
	logic pop;
	logic new_row;
	logic stream_over;
	logic flush_go;
	logic [OUT_WIDTH-1:0] out_head;

	// A finished row waits here until the output FIFO has room
	assign stall = wr_pend & out_full;
	assign out_wr = wr_pend & ~out_full;

	assign pop = start & ~prod.empty & ~stall &
		((state == ACC_IDLE) || (state == ACC_SUM));
	assign prod.rd_en = pop;

	assign new_row = (prod.row_id != cur_row);
	assign stream_over = start & prod.stream_end & prod.empty;

	// Last row goes out once upstream has drained
	assign flush_go = (state == ACC_SUM) & stream_over & ~stall;

	assign wr_load = ((state == ACC_SUM) & pop & new_row) | flush_go;

	////////////////////
	// FSM
	////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ACC_IDLE;
			wr_pend <= 1'b0;
		end else begin
			wr_pend <= wr_load | (wr_pend & ~out_wr);
			case (state)
				ACC_IDLE: begin
					if (pop)
						state <= ACC_SUM;
					else if (stream_over)
						state <= ACC_DONE;    // nothing to write for an empty matrix
				end
				ACC_SUM: begin
					if (flush_go)
						state <= ACC_FLUSH;
				end
				ACC_FLUSH: begin
					if (out_wr)
						state <= ACC_DONE;
				end
				default: begin
					state <= ACC_DONE;
				end
			endcase
		end
	end

	// Running sum and the row being handed off
	always_ff @(posedge clk) begin
		if (pop) begin
			if ((state == ACC_IDLE) || new_row) begin
				cur_row <= prod.row_id;
				cur_sum <= prod.product;
			end else begin
				cur_sum <= cur_sum + prod.product;
			end
		end
		if (wr_load) begin
			wr_row <= cur_row;
			wr_sum <= cur_sum;
		end
	end

	////////////////////
	// Output FIFO
	////////////////////

	sync_fifo #(.width(OUT_WIDTH), .depth_bits(`FIFO_DEPTH_BITS)) out_fifo (
		.clk(clk),
		.rst(rst),
		.din({wr_row, wr_sum}),
		.wr_en(out_wr),
		.rd_en(out_rd_en),
		.dout(out_head),
		.full(out_full),
		.empty(out_empty),
		.count()
	);

	assign {out_row, out_sum} = out_head;

	assign done = (state == ACC_DONE);

endmodule

// ==== source/spmv_lane.sv ====
////////////////////
// Product stream
////////////////////

// Head of the product FIFO plus the end-of-stream flag
interface prod_stream_if import spmv_pkg::*; ();

	mult_t   product;
	row_id_t row_id;
	logic    empty;
	logic    rd_en;
	logic    stream_end;

	modport source (
		output product,
		output row_id,
		output empty,
		output stream_end,
		input  rd_en
	);

	modport sink (
		input  product,
		input  row_id,
		input  empty,
		input  stream_end,
		output rd_en
	);

endinterface

////////////////////
// Lane top
////////////////////

module spmv_lane import spmv_pkg::*; (
	input  logic     clk,
	input  logic     rst,

	// Vector load
	input  logic     vec_wr_en,
	input  col_id_t  vec_wr_addr,
	input  vec_val_t vec_wr_data,

	// Nonzero push, sorted by row
	input  logic     nz_wr_en,
	input  row_id_t  nz_row_id,
	input  col_id_t  nz_col_id,
	input  mat_val_t nz_mat_val,
	output logic     nz_full,

	input  logic     start,
	input  logic     input_done,

	// Finished rows
	output row_id_t  out_row,
	output mult_t    out_sum,
	output logic     out_empty,
	input  logic     out_rd_en,

	output logic     done
);

	prod_stream_if prod ();

	product_stage u_product_stage (
		.clk(clk),
		.rst(rst),
		.start(start),
		.input_done(input_done),
		.vec_wr_en(vec_wr_en),
		.vec_wr_addr(vec_wr_addr),
		.vec_wr_data(vec_wr_data),
		.nz_wr_en(nz_wr_en),
		.nz_row_id(nz_row_id),
		.nz_col_id(nz_col_id),
		.nz_mat_val(nz_mat_val),
		.nz_full(nz_full),
		.prod(prod.source)
	);

	row_accumulator u_row_accumulator (
		.clk(clk),
		.rst(rst),
		.start(start),
		.out_rd_en(out_rd_en),
		.prod(prod.sink),
		.out_row(out_row),
		.out_sum(out_sum),
		.out_empty(out_empty),
		.done(done)
	);

endmodule

// ==== source/spmv_params.svh ====
`ifndef SPMV_PARAMS_SVH
`define SPMV_PARAMS_SVH

// Index widths
`define COL_ID_BITS 8
`define ROW_ID_BITS 8

// Value widths
`define MAT_VAL_BITS 8
`define VEC_VAL_BITS 8

// Products and row sums share one width
`define MULT_BITS (`VEC_VAL_BITS + `MAT_VAL_BITS)

// One vector word per possible column index
`define NUM_VEC_VALS (1 << `COL_ID_BITS)

// Depth of every FIFO in the lane
`define FIFO_DEPTH 8
`define FIFO_DEPTH_BITS 3

`endif

// ==== source/spmv_pkg.sv ====
`include "spmv_params.svh"

package spmv_pkg;

	////////////////////
	// Data types
	////////////////////

	typedef logic [`COL_ID_BITS-1:0] col_id_t;
	typedef logic [`ROW_ID_BITS-1:0] row_id_t;
	typedef logic [`MAT_VAL_BITS-1:0] mat_val_t;
	typedef logic [`VEC_VAL_BITS-1:0] vec_val_t;

	// Product or running row sum
	typedef logic [`MULT_BITS-1:0] mult_t;

	////////////////////
	// Accumulator FSM
	////////////////////

	typedef enum logic [1:0] {
		ACC_IDLE,
		ACC_SUM,
		ACC_FLUSH,
		ACC_DONE
	} acc_state_t;

endpackage

// ==== source/sync_fifo.sv ====
module sync_fifo #(
	parameter int width = 8,
	parameter int depth_bits = 3
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [width-1:0]      din,
	input  logic                  wr_en,
	input  logic                  rd_en,
	output logic [width-1:0]      dout,
	output logic                  full,
	output logic                  empty,
	output logic [depth_bits:0]   count
);

	localparam int depth = 1 << depth_bits;

	logic [width-1:0] mem [depth];
	logic [depth_bits-1:0] wp;
	logic [depth_bits-1:0] rp;
	logic [depth_bits-1:0] wp_next;
	logic [depth_bits-1:0] rp_next;
	logic gb;
	logic same;
	logic push;
	logic pop;

	assign wp_next = wp + depth_bits'(1);
	assign rp_next = rp + depth_bits'(1);

	// Equal pointers mean full or empty and the guard bit decides
	assign same = (wp == rp);
	assign empty = same & ~gb;
	assign full = same & gb;

	// Writes to a full FIFO and reads from an empty one are ignored
	assign push = wr_en & ~full;
	assign pop = rd_en & ~empty;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wp <= '0;
			rp <= '0;
			gb <= 1'b0;
		end else begin
			if (push)
				wp <= wp_next;
			if (pop)
				rp <= rp_next;
			if (push & ~pop & (wp_next == rp))
				gb <= 1'b1;
			else if (pop & ~push)
				gb <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wp] <= din;
	end

	// Show-ahead head
	assign dout = mem[rp];

	assign count = full ? (depth_bits + 1)'(depth) : {1'b0, wp - rp};

endmodule

// ==== spmv_lane.f ====
+incdir+source
source/spmv_pkg.sv
source/sync_fifo.sv
source/product_stage.sv
source/row_accumulator.sv
source/spmv_lane.sv
verification/spmv_lane_tb.sv

// ==== verification/spmv_lane_tb.sv ====
`include "spmv_params.svh"

module spmv_lane_tb import spmv_pkg::*; ();

	localparam int NUM_CASES = 5;
	localparam int VEC_WORDS = `NUM_VEC_VALS;

	logic clk;
	logic rst;
	logic vec_wr_en;
	col_id_t vec_wr_addr;
	vec_val_t vec_wr_data;
	logic nz_wr_en;
	row_id_t nz_row_id;
	col_id_t nz_col_id;
	mat_val_t nz_mat_val;
	logic nz_full;
	logic start;
	logic input_done;
	row_id_t out_row;
	mult_t out_sum;
	logic out_empty;
	logic out_rd_en;
	logic done;

	// Case table with the nonzeros of all cases stored back to back
	string case_name [NUM_CASES];
	int case_fill [NUM_CASES];
	int case_first [NUM_CASES];
	int case_len [NUM_CASES];
	bit case_bp [NUM_CASES];
	row_id_t tab_row [$];
	col_id_t tab_col [$];
	mat_val_t tab_val [$];

	// Reference model state
	vec_val_t vec_model [VEC_WORDS];
	row_id_t exp_row [$];
	mult_t exp_sum [$];

	integer seed;
	int errors;
	int checks;
	int cycles = 0;
	int cycle_limit = 0;
	bit full_seen;

	spmv_lane uut (
		.clk(clk),
		.rst(rst),
		.vec_wr_en(vec_wr_en),
		.vec_wr_addr(vec_wr_addr),
		.vec_wr_data(vec_wr_data),
		.nz_wr_en(nz_wr_en),
		.nz_row_id(nz_row_id),
		.nz_col_id(nz_col_id),
		.nz_mat_val(nz_mat_val),
		.nz_full(nz_full),
		.start(start),
		.input_done(input_done),
		.out_row(out_row),
		.out_sum(out_sum),
		.out_empty(out_empty),
		.out_rd_en(out_rd_en),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			errors++;
			$display("ERROR: no finish within %0d cycles, done never rose", cycle_limit);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_row(input string name, input row_id_t got, input row_id_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_sum(input string name, input mult_t got, input mult_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	////////////////////
	// Case table
	////////////////////

	task automatic add_nz(input int row, input int col, input int val);
		tab_row.push_back(row_id_t'(row));
		tab_col.push_back(col_id_t'(col));
		tab_val.push_back(mat_val_t'(val));
	endtask

	task automatic open_case(input int idx, input string name, input int fill, input bit bp);
		case_name[idx] = name;
		case_fill[idx] = fill;
		case_bp[idx] = bp;
		case_first[idx] = tab_row.size();
	endtask

	task automatic close_case(input int idx);
		case_len[idx] = tab_row.size() - case_first[idx];
	endtask

	task automatic build_table();
		int row;
		// Fill 0 is a ramp, 1 counts down from the top, 2 is random
		open_case(0, "single_row", 0, 1'b0);
		add_nz(5, 1, 3);
		add_nz(5, 10, 17);
		add_nz(5, 100, 250);
		add_nz(5, 200, 9);
		close_case(0);
		open_case(1, "multi_row", 2, 1'b0);
		add_nz(0, 2, 4);
		add_nz(3, 5, 1);
		add_nz(3, 6, 2);
		add_nz(3, 250, 99);
		add_nz(4, 7, 8);
		add_nz(9, 0, 'h40);
		add_nz(9, 255, 'h11);
		add_nz(200, 33, 5);
		close_case(1);
		// Large products push row 7 past the sum width
		open_case(2, "wrap", 1, 1'b0);
		add_nz(7, 0, 'hff);
		add_nz(7, 1, 'hff);
		add_nz(7, 2, 'hff);
		add_nz(7, 3, 'hfe);
		add_nz(8, 4, 'h80);
		close_case(2);
		// Mostly one nonzero per row so rows finish faster than they drain
		open_case(3, "long_backpressure", 2, 1'b1);
		row = 10;
		for (int i = 0; i < 64; i++) begin
			if (i > 0 && ($random(seed) & 3) != 0)
				row = row + 1 + ($random(seed) & 1);
			add_nz(row, $random(seed), $random(seed));
		end
		close_case(3);
		open_case(4, "empty", 0, 1'b0);
		close_case(4);
	endtask

	////////////////////
	// Case steps
	////////////////////

	task automatic reset_dut();
		@(posedge clk);
		#10;
		rst = 1'b1;
		start = 1'b0;
		input_done = 1'b0;
		vec_wr_en = 1'b0;
		nz_wr_en = 1'b0;
		out_rd_en = 1'b0;
		repeat (10) @(posedge clk);
		#10;
		rst = 1'b0;
		if (done || nz_full || !out_empty) begin
			errors++;
			$display("ERROR: lane not idle after reset");
		end
	endtask

	task automatic load_vector(input int idx);
		vec_val_t word;
		for (int a = 0; a < VEC_WORDS; a++) begin
			case (case_fill[idx])
				0: word = vec_val_t'(a * 7 + 3);
				1: word = vec_val_t'(VEC_WORDS - 1 - a);
				default: word = vec_val_t'($random(seed));
			endcase
			vec_model[a] = word;
			@(posedge clk);
			#10;
			vec_wr_en = 1'b1;
			vec_wr_addr = col_id_t'(a);
			vec_wr_data = word;
		end
		@(posedge clk);
		#10;
		vec_wr_en = 1'b0;
	endtask

	// One expected pair per run of equal row index
	task automatic build_model(input int idx);
		row_id_t row;
		mult_t sum;
		mult_t prod;
		exp_row.delete();
		exp_sum.delete();
		for (int i = case_first[idx]; i < case_first[idx] + case_len[idx]; i++) begin
			prod = mult_t'(tab_val[i]) * mult_t'(vec_model[tab_col[i]]);
			if (i != case_first[idx] && tab_row[i] == row) begin
				sum = sum + prod;
			end else begin
				if (i != case_first[idx]) begin
					exp_row.push_back(row);
					exp_sum.push_back(sum);
				end
				row = tab_row[i];
				sum = prod;
			end
		end
		if (case_len[idx] > 0) begin
			exp_row.push_back(row);
			exp_sum.push_back(sum);
		end
	endtask

	task automatic push_nonzeros(input int idx);
		for (int i = case_first[idx]; i < case_first[idx] + case_len[idx]; i++) begin
			@(posedge clk);
			#10;
			while (nz_full) begin
				full_seen = 1'b1;
				nz_wr_en = 1'b0;
				@(posedge clk);
				#10;
			end
			nz_wr_en = 1'b1;
			nz_row_id = tab_row[i];
			nz_col_id = tab_col[i];
			nz_mat_val = tab_val[i];
		end
		@(posedge clk);
		#10;
		nz_wr_en = 1'b0;
		input_done = 1'b1;
	endtask

	task automatic drain_outputs(input int idx);
		int got;
		int hold;
		bit done_seen;
		bit was_empty;
		bit take;
		got = 0;
		hold = 0;
		done_seen = 1'b0;
		was_empty = 1'b1;
		// Watch a few idle cycles after done for late entries
		while (hold < 8) begin
			@(posedge clk);
			#10;
			take = 1'b0;
			if (done_seen && !done) begin
				errors++;
				$display("ERROR: done fell after it had risen in case %s", case_name[idx]);
			end
			if (done_seen && was_empty && !out_empty) begin
				errors++;
				$display("ERROR: an output arrived after done in case %s", case_name[idx]);
			end
			if (done)
				done_seen = 1'b1;
			if (!out_empty) begin
				take = case_bp[idx] ? (($random(seed) & 3) == 0) : 1'b1;
				if (take) begin
					if (got < exp_row.size()) begin
						check_row("out_row", out_row, exp_row[got]);
						check_sum("out_sum", out_sum, exp_sum[got]);
					end else begin
						errors++;
						$display("ERROR: more outputs than rows in case %s", case_name[idx]);
					end
					got++;
				end
			end
			if (done_seen && out_empty)
				hold++;
			was_empty = out_empty;
			out_rd_en = take;
		end
		check_count("output count", got, exp_row.size());
		if (case_bp[idx] && !full_seen) begin
			errors++;
			$display("ERROR: nz_full never rose under back-pressure in case %s", case_name[idx]);
		end
	endtask

	task automatic run_case(input int idx);
		$display("Case %s with %0d nonzeros", case_name[idx], case_len[idx]);
		full_seen = 1'b0;
		reset_dut();
		load_vector(idx);
		build_model(idx);
		@(posedge clk);
		#10;
		start = 1'b1;
		fork
			push_nonzeros(idx);
			drain_outputs(idx);
		join
	endtask

	initial begin
		int total_nz;
		rst = 1'b1;
		vec_wr_en = 1'b0;
		vec_wr_addr = '0;
		vec_wr_data = '0;
		nz_wr_en = 1'b0;
		nz_row_id = '0;
		nz_col_id = '0;
		nz_mat_val = '0;
		start = 1'b0;
		input_done = 1'b0;
		out_rd_en = 1'b0;
		seed = 32'hfabe;
		errors = 0;
		checks = 0;
		build_table();
		total_nz = tab_row.size();
		cycle_limit = 300 * NUM_CASES + 20 * total_nz;
		for (int c = 0; c < NUM_CASES; c++)
			run_case(c);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
